/* common/exec_pkg.sv */
// Execute stage definitions
`default_nettype none

package exec_pkg;

    localparam int XLEN        = 32;
    localparam int TAG_W       = 3;
    localparam int LINK_OFFSET = 4;

    typedef logic [XLEN-1:0]  word_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [3:0]       wstrb_t;
    typedef logic [4:0]       shamt_t;

    //////////////////////////////////////////////////////////////////////
    // Operations
    //////////////////////////////////////////////////////////////////////

    // Codes run from 0 in declaration order
    typedef enum logic [5:0] {
        NOP,                            // 0
        ADD, SUB, AND, OR, XOR,         // 1 to 5
        SLL, SRL, SRA,                  // 6 to 8
        SLT, SLTU, LUI,                 // 9 to 11
        JAL, JALR,                      // 12, 13
        BEQ, BNE, BLT, BLTU, BGE, BGEU, // 14 to 19
        LB, LBU, LH, LHU, LW,           // 20 to 24
        SB, SH, SW                      // 25 to 27
    } exec_op_e;

    //////////////////////////////////////////////////////////////////////
    // Datapath controls
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        RES_SUM,    // Main adder
        RES_ALT,    // Second adder or passed rs2
        RES_AND,
        RES_OR,
        RES_XOR,
        RES_SLL,
        RES_SHR,    // Logical or arithmetic right shift
        RES_CMP     // Comparator bit
    } result_sel_e;

    typedef enum logic [2:0] {
        BR_NEVER,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_LTU,
        BR_GE,
        BR_GEU,
        BR_ALWAYS
    } branch_cond_e;

    typedef enum logic [1:0] {
        ST_NONE,
        ST_BYTE,
        ST_HALF,
        ST_WORD
    } store_size_e;

endpackage

`default_nettype wire

/* hw/op_decode.sv */
// Operation decoder
`default_nettype none

module op_decode (
    input  exec_pkg::exec_op_e     op_i,
    output exec_pkg::result_sel_e  result_sel_o,
    output exec_pkg::branch_cond_e branch_cond_o,
    output logic                   sub_o,
    output logic                   link_o,
    output logic                   load_o,
    output exec_pkg::store_size_e  store_size_o,
    output logic                   writes_rd_o,
    output logic                   jalr_o
);

    import exec_pkg::*;

    // SRA shares the alternate flag with SUB, as in the ISA encoding
    assign sub_o       = op_i inside {SUB, SRA};
    assign link_o      = op_i inside {JAL, JALR};
    assign jalr_o      = op_i == JALR;
    assign load_o      = op_i inside {LB, LBU, LH, LHU, LW};
    assign writes_rd_o = !(op_i inside {NOP, BEQ, BNE, BLT, BLTU, BGE, BGEU, SB, SH, SW});

    always_comb begin
        case (op_i)
            SUB, LUI, JAL, JALR: result_sel_o = RES_ALT;
            AND:                 result_sel_o = RES_AND;
            OR:                  result_sel_o = RES_OR;
            XOR:                 result_sel_o = RES_XOR;
            SLL:                 result_sel_o = RES_SLL;
            SRL, SRA:            result_sel_o = RES_SHR;
            SLT, SLTU:           result_sel_o = RES_CMP;
            default:             result_sel_o = RES_SUM;
        endcase
    end

    // Set-less-than reuses the branch comparator
    always_comb begin
        case (op_i)
            BEQ:       branch_cond_o = BR_EQ;
            BNE:       branch_cond_o = BR_NE;
            BLT, SLT:  branch_cond_o = BR_LT;
            BLTU, SLTU: branch_cond_o = BR_LTU;
            BGE:       branch_cond_o = BR_GE;
            BGEU:      branch_cond_o = BR_GEU;
            JAL, JALR: branch_cond_o = BR_ALWAYS;
            default:   branch_cond_o = BR_NEVER;
        endcase
    end

    always_comb begin
        case (op_i)
            SB:      store_size_o = ST_BYTE;
            SH:      store_size_o = ST_HALF;
            SW:      store_size_o = ST_WORD;
            default: store_size_o = ST_NONE;
        endcase
    end

    // Every known operation maps to a defined result source
    always_comb begin
        if (!$isunknown(op_i)) begin
            assert final (!$isunknown(result_sel_o))
                else $error("result select unknown for op %0d", op_i);
        end
    end

endmodule

`default_nettype wire

/* hw/int_execute.sv */
// Integer execute datapath
`default_nettype none

module int_execute (
    input  exec_pkg::word_t        pc_i,
    input  exec_pkg::word_t        rs1_val_i,
    input  exec_pkg::word_t        rs2_val_i,
    input  exec_pkg::word_t        imm_i,
    input  exec_pkg::result_sel_e  result_sel_i,
    input  exec_pkg::branch_cond_e branch_cond_i,
    input  logic                   sub_i,
    input  logic                   link_i,
    input  logic                   jalr_i,
    input  exec_pkg::store_size_e  store_size_i,
    output exec_pkg::word_t        result_o,
    output logic                   taken_o,
    output exec_pkg::word_t        target_o,
    output exec_pkg::word_t        mem_addr_o,
    output exec_pkg::wstrb_t       store_strb_o,
    output exec_pkg::word_t        store_data_o
);

    import exec_pkg::*;

    logic signed [XLEN-1:0] rs1_signed;
    logic signed [XLEN-1:0] rs2_signed;
    word_t                  sum;
    word_t                  alt_a;
    word_t                  alt_b;
    word_t                  alt_sum;
    shamt_t                 shamt;
    word_t                  srl_res;
    word_t                  sra_res;
    logic                   equal;
    logic                   less;
    logic                   less_u;
    logic                   cond_met;

    assign rs1_signed = rs1_val_i;
    assign rs2_signed = rs2_val_i;

    //////////////////////////////////////////////////////////////////////
    // Adders and compare
    //////////////////////////////////////////////////////////////////////

    assign sum = rs1_val_i + rs2_val_i;

    // Second adder. Subtract is rs1 plus inverted rs2 plus one
    always_comb begin
        if (sub_i) begin
            alt_a = rs1_val_i;
            alt_b = ~rs2_val_i;
        end else if (link_i) begin
            alt_a = pc_i;
            alt_b = word_t'(LINK_OFFSET);
        end else begin
            alt_a = pc_i;
            alt_b = imm_i;
        end
    end

    assign alt_sum = alt_a + alt_b + word_t'(sub_i);

    assign equal  = rs1_val_i == rs2_val_i;
    assign less   = rs1_signed < rs2_signed;
    assign less_u = rs1_val_i < rs2_val_i;

    always_comb begin
        case (branch_cond_i)
            BR_NEVER:  cond_met = 1'b0;
            BR_EQ:     cond_met = equal;
            BR_NE:     cond_met = !equal;
            BR_LT:     cond_met = less;
            BR_LTU:    cond_met = less_u;
            BR_GE:     cond_met = !less;
            BR_GEU:    cond_met = !less_u;
            BR_ALWAYS: cond_met = 1'b1;
        endcase
    end

    // Compare results never redirect the flow
    assign taken_o = cond_met && (result_sel_i != RES_CMP);

    //////////////////////////////////////////////////////////////////////
    // Result select
    //////////////////////////////////////////////////////////////////////

    assign shamt   = rs2_val_i[4:0];
    assign srl_res = rs1_val_i >> shamt;
    assign sra_res = rs1_signed >>> shamt;

    always_comb begin
        case (result_sel_i)
            RES_SUM: result_o = sum;
            RES_ALT: result_o = (sub_i || link_i) ? alt_sum : rs2_val_i;
            RES_AND: result_o = rs1_val_i & rs2_val_i;
            RES_OR:  result_o = rs1_val_i | rs2_val_i;
            RES_XOR: result_o = rs1_val_i ^ rs2_val_i;
            RES_SLL: result_o = rs1_val_i << shamt;
            RES_SHR: result_o = sub_i ? sra_res : srl_res;
            RES_CMP: result_o = {{(XLEN-1){1'b0}}, cond_met};
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Targets and memory
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (jalr_i) begin
            target_o = {sum[XLEN-1:1], 1'b0};
        end else if (link_i) begin
            target_o = sum;
        end else begin
            target_o = alt_sum;
        end
    end

    assign mem_addr_o = {sum[XLEN-1:2], 2'b00};

    always_comb begin
        case (store_size_i)
            ST_BYTE: store_strb_o = wstrb_t'(1) << sum[1:0];
            ST_HALF: store_strb_o = sum[1] ? 4'b1100 : 4'b0011;
            ST_WORD: store_strb_o = 4'b1111;
            ST_NONE: store_strb_o = 4'b0000;
        endcase
    end

    // Narrow stores repeat their data on every lane
    always_comb begin
        case (store_size_i)
            ST_BYTE: store_data_o = {4{imm_i[7:0]}};
            ST_HALF: store_data_o = {2{imm_i[15:0]}};
            default: store_data_o = imm_i;
        endcase
    end

    always_comb begin
        if (store_size_i == ST_BYTE) begin
            assert final ($onehot(store_strb_o))
                else $error("byte store drives strobes %b", store_strb_o);
        end
    end

endmodule

`default_nettype wire

/* hw/stage_retire.sv */
// Handshake, tag kill and output register
`default_nettype none

module stage_retire (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  in_valid_i,
    input  logic                  out_ready_i,
    input  exec_pkg::tag_t        tag_i,
    input  exec_pkg::exec_op_e    op_i,
    input  logic                  writes_rd_i,
    input  logic                  load_i,
    input  logic                  taken_i,
    input  exec_pkg::wstrb_t      store_strb_i,
    input  exec_pkg::word_t       result_i,
    output logic                  in_ready_o,
    output logic                  out_valid_o,
    output logic                  jump_o,
    output logic                  mem_read_o,
    output exec_pkg::wstrb_t      mem_wstrb_o,
    output exec_pkg::exec_op_e    out_op_o,
    output exec_pkg::word_t       out_result_o,
    output logic                  out_write_enable_o,
    output logic                  out_killed_o
);

    import exec_pkg::*;

    tag_t cur_tag;
    logic fire;
    logic killed;
    logic live;

    // Accept when the output slot is free or drains this cycle
    assign in_ready_o = !out_valid_o || out_ready_i;
    assign fire       = in_valid_i && in_ready_o;
    assign killed     = tag_i != cur_tag;
    assign live       = fire && !killed;

    //////////////////////////////////////////////////////////////////////
    // Side effects and flow tag
    //////////////////////////////////////////////////////////////////////

    assign jump_o      = live && taken_i;
    assign mem_read_o  = live && load_i;
    assign mem_wstrb_o = live ? store_strb_i : '0;

    // Younger instructions of the old flow carry the stale tag
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cur_tag <= '0;
        end else if (jump_o) begin
            cur_tag <= cur_tag + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out_valid_o        <= 1'b0;
            out_op_o           <= NOP;
            out_result_o       <= '0;
            out_write_enable_o <= 1'b0;
            out_killed_o       <= 1'b0;
        end else if (fire) begin
            out_valid_o        <= 1'b1;
            out_op_o           <= op_i;
            out_result_o       <= result_i;
            out_write_enable_o <= writes_rd_i && !killed;
            out_killed_o       <= killed;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    // A jump only leaves on a transfer and moves the tag once
    assert property (@(posedge clk) disable iff (!reset_n)
        jump_o |-> fire ##1 (cur_tag == tag_t'($past(cur_tag) + 1'b1)))
        else $error("jump without fire or tag not advanced");

    assert property (@(posedge clk) disable iff (!reset_n)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_op_o) &&
            $stable(out_result_o) && $stable(out_write_enable_o) && $stable(out_killed_o))
        else $error("output changed while stalled");

endmodule

`default_nettype wire

/* hw/exec_stage.sv */
// RV32 execute stage top
`default_nettype none

module exec_stage (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  exec_pkg::exec_op_e    op_i,
    input  exec_pkg::word_t       pc_i,
    input  exec_pkg::word_t       rs1_val_i,
    input  exec_pkg::word_t       rs2_val_i,
    input  exec_pkg::word_t       imm_i,
    input  exec_pkg::tag_t        tag_i,
    output logic                  jump_o,
    output exec_pkg::word_t       jump_target_o,
    output logic                  mem_read_o,
    output exec_pkg::wstrb_t      mem_wstrb_o,
    output exec_pkg::word_t       mem_addr_o,
    output exec_pkg::word_t       mem_wdata_o,
    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output exec_pkg::exec_op_e    out_op_o,
    output exec_pkg::word_t       out_result_o,
    output logic                  out_write_enable_o,
    output logic                  out_killed_o
);

    import exec_pkg::*;

    // Decode controls
    result_sel_e  result_sel;
    branch_cond_e branch_cond;
    logic         sub;
    logic         link;
    logic         load;
    store_size_e  store_size;
    logic         writes_rd;
    logic         jalr;

    // Datapath values
    word_t        result;
    logic         taken;
    wstrb_t       store_strb;

    op_decode u_decode (
        .op_i          (op_i),
        .result_sel_o  (result_sel),
        .branch_cond_o (branch_cond),
        .sub_o         (sub),
        .link_o        (link),
        .load_o        (load),
        .store_size_o  (store_size),
        .writes_rd_o   (writes_rd),
        .jalr_o        (jalr)
    );

    int_execute u_execute (
        .pc_i          (pc_i),
        .rs1_val_i     (rs1_val_i),
        .rs2_val_i     (rs2_val_i),
        .imm_i         (imm_i),
        .result_sel_i  (result_sel),
        .branch_cond_i (branch_cond),
        .sub_i         (sub),
        .link_i        (link),
        .jalr_i        (jalr),
        .store_size_i  (store_size),
        .result_o      (result),
        .taken_o       (taken),
        .target_o      (jump_target_o),
        .mem_addr_o    (mem_addr_o),
        .store_strb_o  (store_strb),
        .store_data_o  (mem_wdata_o)
    );

    stage_retire u_retire (
        .clk                (clk),
        .reset_n            (reset_n),
        .in_valid_i         (in_valid_i),
        .out_ready_i        (out_ready_i),
        .tag_i              (tag_i),
        .op_i               (op_i),
        .writes_rd_i        (writes_rd),
        .load_i             (load),
        .taken_i            (taken),
        .store_strb_i       (store_strb),
        .result_i           (result),
        .in_ready_o         (in_ready_o),
        .out_valid_o        (out_valid_o),
        .jump_o             (jump_o),
        .mem_read_o         (mem_read_o),
        .mem_wstrb_o        (mem_wstrb_o),
        .out_op_o           (out_op_o),
        .out_result_o       (out_result_o),
        .out_write_enable_o (out_write_enable_o),
        .out_killed_o       (out_killed_o)
    );

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
// Testbench clock and reset
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic reset_n_o
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 2;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Release just after an edge, like the other stimulus
    initial begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        reset_n_o = 1'b1;
    end

endmodule

`default_nettype wire

/* verif/tb_exec_stage.sv */
// Execute stage testbench
`default_nettype none

module tb_exec_stage;

    timeunit 1ns;
    timeprecision 1ps;

    import exec_pkg::*;

    localparam string STIM_FILE       = "verif/exec_stimulus.txt";
    localparam int    SEED            = 32'h848d;
    localparam int    WATCHDOG_MARGIN = 50;
    localparam int    CYCLES_PER_LINE = 20;
    localparam int    DRIVE_DELAY     = 1;
    localparam int    SAMPLE_DELAY    = 1;
    localparam int    FIELDS          = 15;

    typedef struct packed {
        exec_op_e op;
        word_t    pc;
        word_t    rs1;
        word_t    rs2;
        word_t    imm;
        tag_t     tag;
        word_t    result;
        logic     write_enable;
        logic     killed;
        logic     jump;
        word_t    target;
        logic     read;
        wstrb_t   strb;
        word_t    addr;
        word_t    wdata;
    } vector_t;

    logic     clk;
    logic     reset_n;
    logic     in_valid_i;
    logic     in_ready_o;
    exec_op_e op_i;
    word_t    pc_i;
    word_t    rs1_val_i;
    word_t    rs2_val_i;
    word_t    imm_i;
    tag_t     tag_i;
    logic     jump_o;
    word_t    jump_target_o;
    logic     mem_read_o;
    wstrb_t   mem_wstrb_o;
    word_t    mem_addr_o;
    word_t    mem_wdata_o;
    logic     out_valid_o;
    logic     out_ready_i;
    exec_op_e out_op_o;
    word_t    out_result_o;
    logic     out_write_enable_o;
    logic     out_killed_o;

    vector_t  vectors[$];
    int       pending_q[$];
    int       next_idx;
    int       seed;
    bit       loaded;

    tb_clock_gen u_clock_gen (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    exec_stage dut (
        .clk                (clk),
        .reset_n            (reset_n),
        .in_valid_i         (in_valid_i),
        .in_ready_o         (in_ready_o),
        .op_i               (op_i),
        .pc_i               (pc_i),
        .rs1_val_i          (rs1_val_i),
        .rs2_val_i          (rs2_val_i),
        .imm_i              (imm_i),
        .tag_i              (tag_i),
        .jump_o             (jump_o),
        .jump_target_o      (jump_target_o),
        .mem_read_o         (mem_read_o),
        .mem_wstrb_o        (mem_wstrb_o),
        .mem_addr_o         (mem_addr_o),
        .mem_wdata_o        (mem_wdata_o),
        .out_valid_o        (out_valid_o),
        .out_ready_i        (out_ready_i),
        .out_op_o           (out_op_o),
        .out_result_o       (out_result_o),
        .out_write_enable_o (out_write_enable_o),
        .out_killed_o       (out_killed_o)
    );

    //////////////////////////////////////////////////////////////////////
    // Compare helpers
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_strb(input string what, input wstrb_t got, input wstrb_t exp);
        if (got !== exp) begin
            $display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_op(input string what, input exec_op_e got, input exec_op_e exp);
        if (got !== exp) begin
            $display("ERR %0t ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Vectors, driving and per-item checks
    //////////////////////////////////////////////////////////////////////

    task automatic load_vectors();
        int      fd;
        int      count;
        string   line;
        int      op_v, tag_v, we_v, kill_v, jump_v, read_v, strb_v;
        word_t   pc_v, rs1_v, rs2_v, imm_v, res_v, tgt_v, addr_v, wdata_v;
        vector_t v;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file %s", STIM_FILE);
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Comment and blank lines match no field
            count = $sscanf(line, "%d %h %h %h %h %d %h %d %d %d %h %d %h %h %h",
                op_v, pc_v, rs1_v, rs2_v, imm_v, tag_v, res_v, we_v, kill_v,
                jump_v, tgt_v, read_v, strb_v, addr_v, wdata_v);
            if (count == FIELDS) begin
                v.op           = exec_op_e'(op_v[5:0]);
                v.pc           = pc_v;
                v.rs1          = rs1_v;
                v.rs2          = rs2_v;
                v.imm          = imm_v;
                v.tag          = tag_t'(tag_v);
                v.result       = res_v;
                v.write_enable = we_v[0];
                v.killed       = kill_v[0];
                v.jump         = jump_v[0];
                v.target       = tgt_v;
                v.read         = read_v[0];
                v.strb         = wstrb_t'(strb_v);
                v.addr         = addr_v;
                v.wdata        = wdata_v;
                vectors.push_back(v);
            end else if (count > 0) begin
                $display("Malformed stimulus line: %s", line);
                abort_run();
            end
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            $display("Stimulus file %s holds no vectors", STIM_FILE);
            abort_run();
        end
    endtask

    task automatic drive_vector(input vector_t v);
        in_valid_i = 1'b1;
        op_i       = v.op;
        pc_i       = v.pc;
        rs1_val_i  = v.rs1;
        rs2_val_i  = v.rs2;
        imm_i      = v.imm;
        tag_i      = v.tag;
    endtask

    task automatic check_reset_state();
        check_bit("out_valid_o after reset", out_valid_o, 1'b0);
        check_bit("out_write_enable_o after reset", out_write_enable_o, 1'b0);
        check_bit("out_killed_o after reset", out_killed_o, 1'b0);
        check_op("out_op_o after reset", out_op_o, NOP);
        check_word("out_result_o after reset", out_result_o, '0);
        check_bit("in_ready_o after reset", in_ready_o, 1'b1);
    endtask

    // Side effects are combinational, so they are read in the fire cycle
    task automatic check_fire(input int idx);
        vector_t v;
        string   who;
        v   = vectors[idx];
        who = $sformatf("vector %0d", idx);
        check_bit({who, " jump_o"}, jump_o, v.jump);
        if (v.jump) begin
            check_word({who, " jump_target_o"}, jump_target_o, v.target);
        end
        check_bit({who, " mem_read_o"}, mem_read_o, v.read);
        check_strb({who, " mem_wstrb_o"}, mem_wstrb_o, v.strb);
        check_word({who, " mem_addr_o"}, mem_addr_o, v.addr);
        check_word({who, " mem_wdata_o"}, mem_wdata_o, v.wdata);
    endtask

    task automatic check_stalled();
        check_bit("jump_o while stalled", jump_o, 1'b0);
        check_bit("mem_read_o while stalled", mem_read_o, 1'b0);
        check_strb("mem_wstrb_o while stalled", mem_wstrb_o, 4'b0000);
    endtask

    task automatic check_retire(input int idx);
        vector_t v;
        string   who;
        v   = vectors[idx];
        who = $sformatf("vector %0d", idx);
        check_op({who, " out_op_o"}, out_op_o, v.op);
        check_word({who, " out_result_o"}, out_result_o, v.result);
        check_bit({who, " out_write_enable_o"}, out_write_enable_o, v.write_enable);
        check_bit({who, " out_killed_o"}, out_killed_o, v.killed);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main flow and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin : main_flow
        int rnd;
        bit exp_valid;
        bit exp_ready;
        seed        = SEED;
        loaded      = 1'b0;
        in_valid_i  = 1'b0;
        op_i        = NOP;
        pc_i        = '0;
        rs1_val_i   = '0;
        rs2_val_i   = '0;
        imm_i       = '0;
        tag_i       = '0;
        out_ready_i = 1'b0;
        next_idx    = 0;
        load_vectors();
        loaded = 1'b1;
        @(posedge reset_n);
        #SAMPLE_DELAY;
        check_reset_state();
        while (next_idx < vectors.size() || pending_q.size() != 0) begin
            @(posedge clk);
            #DRIVE_DELAY;
            // Sink is ready about three cycles in four
            rnd         = $random(seed);
            out_ready_i = rnd[1:0] != 2'b00;
            if (next_idx < vectors.size()) begin
                drive_vector(vectors[next_idx]);
            end else begin
                in_valid_i = 1'b0;
            end
            #SAMPLE_DELAY;
            // An item fired last cycle must be waiting in the output register
            exp_valid = pending_q.size() != 0;
            exp_ready = !exp_valid || out_ready_i;
            check_bit("out_valid_o", out_valid_o, exp_valid);
            check_bit("in_ready_o", in_ready_o, exp_ready);
            if (exp_valid && out_ready_i) begin
                check_retire(pending_q.pop_front());
            end
            if (in_valid_i && exp_ready) begin
                check_fire(next_idx);
                pending_q.push_back(next_idx);
                next_idx++;
            end else if (in_valid_i) begin
                check_stalled();
            end
        end
        $display("TESTS PASSED");
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = vectors.size() * CYCLES_PER_LINE + WATCHDOG_MARGIN;
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the stage stopped making progress", limit);
        abort_run();
    end

endmodule

`default_nettype wire

/* verif/exec_stimulus.txt */
// op pc rs1 rs2 imm tag | result we killed jump target read strb addr wdata
// op, tag and flags in decimal, the rest in hex; target is checked only on a jump
1  00000100 00000005 00000007 00000000 0  0000000c 1 0 0 00000000 0 0 0000000c 00000000
2  00000104 00000003 00000005 00000000 0  fffffffe 1 0 0 00000000 0 0 00000008 00000000
3  00000108 f0f0f0f0 ff00ff00 00000000 0  f000f000 1 0 0 00000000 0 0 eff1eff0 00000000
4  0000010c 12340000 00005678 00000000 0  12345678 1 0 0 00000000 0 0 12345678 00000000
5  00000110 aaaa5555 ffff0000 00000000 0  55555555 1 0 0 00000000 0 0 aaa95554 00000000
6  00000114 00000001 0000001f 00000000 0  80000000 1 0 0 00000000 0 0 00000020 00000000
7  00000118 80000000 00000004 00000000 0  08000000 1 0 0 00000000 0 0 80000004 00000000
8  0000011c ffff0000 00000023 00000000 0  ffffe000 1 0 0 00000000 0 0 ffff0020 00000000
9  00000120 ffffffff 00000001 00000000 0  00000001 1 0 0 00000000 0 0 00000000 00000000
10 00000124 ffffffff 00000001 00000000 0  00000000 1 0 0 00000000 0 0 00000000 00000000
11 00000128 00000000 abcde000 00000000 0  abcde000 1 0 0 00000000 0 0 abcde000 00000000
14 00000200 00000010 00000010 00000040 0  00000020 0 0 1 00000240 0 0 00000020 00000040
1  00000204 00000001 00000002 00000000 0  00000003 0 1 0 00000000 0 0 00000000 00000000
15 00000240 00000001 00000002 00000020 1  00000003 0 0 1 00000260 0 0 00000000 00000020
16 00000260 ffffffff 00000001 00000010 2  00000000 0 0 1 00000270 0 0 00000000 00000010
17 00000270 ffffffff 00000001 00000010 3  00000000 0 0 0 00000000 0 0 00000000 00000010
18 00000274 00000001 ffffffff 0000000c 3  00000000 0 0 1 00000280 0 0 00000000 0000000c
19 00000280 00000001 ffffffff 00000008 4  00000000 0 0 0 00000000 0 0 00000000 00000008
12 00000300 00000300 00000100 00000000 4  00000304 1 0 1 00000400 0 0 00000400 00000000
13 00000400 00001001 00000002 00000000 5  00000404 1 0 1 00001002 0 0 00001000 00000000
24 00000404 00001000 00000004 00000000 5  00001004 0 1 0 00000000 0 0 00001004 00000000
27 00000408 00001000 00000008 deadbeef 5  00001008 0 1 0 00000000 0 0 00001008 deadbeef
12 0000040c 00000000 00000800 00000000 5  00000410 0 1 0 00000000 0 0 00000800 00000000
24 00000500 00001000 00000004 00000000 6  00001004 1 0 0 00000000 1 0 00001004 00000000
20 00000504 00001000 00000003 00000000 6  00001003 1 0 0 00000000 1 0 00001000 00000000
25 00000508 00002000 00000000 000000a5 6  00002000 0 0 0 00000000 0 1 00002000 a5a5a5a5
25 0000050c 00002000 00000001 123456b7 6  00002001 0 0 0 00000000 0 2 00002000 b7b7b7b7
25 00000510 00002000 00000002 000000c9 6  00002002 0 0 0 00000000 0 4 00002000 c9c9c9c9
25 00000514 00002000 00000003 0000003e 6  00002003 0 0 0 00000000 0 8 00002000 3e3e3e3e
26 00000518 00002000 00000000 ffff1234 6  00002000 0 0 0 00000000 0 3 00002000 12341234
26 0000051c 00002000 00000002 0000beef 6  00002002 0 0 0 00000000 0 c 00002000 beefbeef
27 00000520 00002000 00000004 cafef00d 6  00002004 0 0 0 00000000 0 f 00002004 cafef00d

/* verilog.f */
common/exec_pkg.sv
hw/op_decode.sv
hw/int_execute.sv
hw/stage_retire.sv
hw/exec_stage.sv
verif/tb_clock_gen.sv
verif/tb_exec_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
    --top-module tb_exec_stage -Mdir obj_dir -o sim_exec_stage -f verilog.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_exec_stage
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

echo "Simulation finished without errors"
exit 0
